/* dmem_ctrl.f */
design/dmem_pkg.sv
design/dmem_req_if.sv
design/dmem_access_chk.sv
design/dmem_biu_ctrl.sv
design/dmem_resp.sv
design/dmem_ctrl.sv
verification/dmem_bus_model.sv
verification/dmem_ctrl_tb.sv

/* Bender.yml */
package:
  name: dmem_ctrl

sources:
  # Package and interface first
  - design/dmem_pkg.sv
  - design/dmem_req_if.sv
  - design/dmem_access_chk.sv
  - design/dmem_biu_ctrl.sv
  - design/dmem_resp.sv
  - design/dmem_ctrl.sv

  - target: test
    files:
      - verification/dmem_bus_model.sv
      - verification/dmem_ctrl_tb.sv

/* verification/dmem_ctrl_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_ctrl_tb
  import dmem_pkg::*;
();

  localparam int PMA_CNT     = 3;
  localparam int N_RAND      = 200;
  // Directed accesses of tests 1 to 5 plus random traffic
  localparam int N_ACCESS    = 16 + 15 + 8 + 5 + 4 + N_RAND;
  localparam int CYCLE_LIMIT = 40 * N_ACCESS;

  // Response kinds as {ack, err, misaligned}
  localparam logic [2:0] KIND_ACK = 3'b100;
  localparam logic [2:0] KIND_ERR = 3'b010;
  localparam logic [2:0] KIND_MIS = 3'b011;

  logic      clk;
  logic      rst;
  prv_t      st_prv;
  pmacfg_t   pma_cfg  [PMA_CNT];
  word_t     pma_base [PMA_CNT];
  word_t     pma_top  [PMA_CNT];
  logic      mem_req;
  word_t     mem_adr;
  mem_size_t mem_size;
  logic      mem_we;
  word_t     mem_d;
  word_t     mem_q;
  logic      mem_ack;
  logic      mem_err;
  logic      mem_mis;
  logic      biu_stb;
  word_t     biu_adr;
  byte_en_t  biu_be;
  logic      biu_we;
  prot_t     biu_prot;
  word_t     biu_d;
  word_t     biu_q;
  logic      biu_ack;
  logic      biu_err;

  // Expected bus view of the access in flight
  logic       stb_ok;
  prot_t      exp_prot;
  word_t      exp_adr;
  byte_en_t   exp_be;
  logic       exp_we;
  word_t      exp_wd;
  logic [7:0] shadow [16384];
  integer     seed;
  int         cycles;
  int         checks;
  int         errors;
  int         test_errors;
  int         tests_passed;
  int         tests_failed;

  dmem_ctrl #(.PMA_CNT(PMA_CNT)) DUT (
    .clk_i(clk), .rst_i(rst), .st_prv_i(st_prv),
    .pma_cfg_i(pma_cfg), .pma_base_i(pma_base), .pma_top_i(pma_top),
    .mem_req_i(mem_req), .mem_adr_i(mem_adr), .mem_size_i(mem_size),
    .mem_we_i(mem_we), .mem_d_i(mem_d), .mem_q_o(mem_q), .mem_ack_o(mem_ack),
    .mem_err_o(mem_err), .mem_misaligned_o(mem_mis),
    .biu_stb_o(biu_stb), .biu_adr_o(biu_adr), .biu_be_o(biu_be), .biu_we_o(biu_we),
    .biu_prot_o(biu_prot), .biu_d_o(biu_d), .biu_q_i(biu_q),
    .biu_ack_i(biu_ack), .biu_err_i(biu_err)
  );

  dmem_bus_model #(.SEED(32'he45b_424b)) bus_inst (
    .clk_i(clk), .rst_i(rst), .stb_i(biu_stb), .adr_i(biu_adr), .be_i(biu_be),
    .we_i(biu_we), .d_i(biu_d), .q_o(biu_q), .ack_o(biu_ack), .err_o(biu_err)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Outcome from the PMA table and alignment
  // Shadow memory updated on success
  function automatic void predict(input word_t adr, input mem_size_t size, input logic we,
                                  input word_t d, output logic [2:0] kind,
                                  output word_t q, output logic stb,
                                  output byte_en_t be, output word_t wd);
    int    region;
    int    nbytes;
    word_t base;
    logic  mis;
    logic  fault;
    region = -1;
    for (int r = PMA_CNT - 1; r >= 0; r--)
      if (adr >= pma_base[r] && adr <= pma_top[r])
        region = r;
    nbytes = (size == BYTE) ? 1 : ((size == HWORD) ? 2 : 4);
    mis    = (adr % nbytes) != 0;
    fault  = 1'b1;
    if (region >= 0)
    begin
      // MA regions absorb misalignment
      if (pma_cfg[region][PMA_MA])
        mis = 1'b0;
      fault = we ? !pma_cfg[region][PMA_W] : !pma_cfg[region][PMA_R];
    end
    stb = !mis && !fault;
    q   = '0;
    // Held to its own lane
    base = adr - (adr % nbytes);
    be   = '0;
    wd   = '0;
    for (int i = 0; i < nbytes; i++)
    begin
      be[base[1:0] + i]             = 1'b1;
      wd[8 * (base[1:0] + i) +: 8] = d[8*i +: 8];
    end
    if (mis)
      kind = KIND_MIS;
    else if (fault || (adr >= 32'h0f00 && adr <= 32'h0fff))
      kind = KIND_ERR;
    else
    begin
      kind = KIND_ACK;
      for (int i = 0; i < nbytes; i++)
      begin
        if (we)
          shadow[base + i] = d[8*i +: 8];
        else
          q[8*i +: 8] = shadow[base + i];
      end
    end
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_kind(input string name, input logic [2:0] got, input logic [2:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_prot(input string name, input prot_t got, input prot_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_be(input string name, input byte_en_t got, input byte_en_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Strobe only for legal accesses
  // Whole bus view compared on every strobe cycle
  always @(negedge clk)
  begin
    word_t lanes;
    for (int j = 0; j < 4; j++)
      lanes[8*j +: 8] = {8{exp_be[j]}};
    if (!rst && biu_stb)
    begin
      if (!stb_ok)
      begin
        errors++;
        $display("Strobe raised at %h for an access that failed its checks", biu_adr);
      end
      else
      begin
        check_prot("biu_prot_o", biu_prot, exp_prot);
        check_word("biu_adr_o", biu_adr, exp_adr);
        check_be("biu_be_o", biu_be, exp_be);
        check_bit("biu_we_o", biu_we, exp_we);
        // Enabled lanes only
        if (exp_we)
          check_word("biu_d_o", biu_d & lanes, exp_wd);
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, an access never completed", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // One CPU request held until the response pulse
  task automatic run_access(input word_t adr, input mem_size_t size, input logic we,
                            input word_t d, input prv_t prv);
    logic [2:0] exp_kind;
    word_t      exp_q;
    logic       exp_stb;
    byte_en_t   lane_be;
    word_t      lane_d;
    predict(adr, size, we, d, exp_kind, exp_q, exp_stb, lane_be, lane_d);
    @(posedge clk);
    stb_ok              = exp_stb;
    exp_adr             = adr & ~32'h3;
    exp_be              = lane_be;
    exp_we              = we;
    exp_wd              = lane_d;
    exp_prot            = '0;
    exp_prot[PROT_DATA] = 1'b1;
    exp_prot[PROT_PRIV] = (prv != PRV_U);
    mem_req  <= 1'b1;
    mem_adr  <= adr;
    mem_size <= size;
    mem_we   <= we;
    mem_d    <= d;
    st_prv   <= prv;
    do
      @(negedge clk);
    while (!(mem_ack || mem_err));
    check_kind("{mem_ack_o,mem_err_o,mem_misaligned_o}", {mem_ack, mem_err, mem_mis},
               exp_kind);
    if (exp_kind == KIND_ACK && !we)
      check_word("mem_q_o", mem_q, exp_q);
    @(posedge clk);
    mem_req <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    if (errors == test_errors)
    begin
      tests_passed++;
      $display("%-34s ok", name);
    end
    else
    begin
      tests_failed++;
      $display("%-34s %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial
  begin
    int unsigned region;
    word_t       adr;
    word_t       off;
    seed     = 32'he45b_424b;
    rst      = 1'b1;
    st_prv   = PRV_M;
    mem_req  = 1'b0;
    mem_adr  = '0;
    mem_size = WORD;
    mem_we   = 1'b0;
    mem_d    = '0;
    stb_ok   = 1'b0;
    exp_prot = '0;
    exp_adr  = '0;
    exp_be   = '0;
    exp_we   = 1'b0;
    exp_wd   = '0;
    cycles   = 0;
    checks   = 0;
    errors   = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    // RAM, ROM and I/O regions
    pma_base[0] = 32'h0000;
    pma_top[0]  = 32'h0fff;
    pma_cfg[0]  = 3'b011;
    pma_base[1] = 32'h1000;
    pma_top[1]  = 32'h1fff;
    pma_cfg[1]  = 3'b001;
    pma_base[2] = 32'h2000;
    pma_top[2]  = 32'h20ff;
    pma_cfg[2]  = 3'b111;
    // Same fill as the bus model memory
    for (int a = 0; a < 16384; a++)
      shadow[a] = 8'(a ^ (a >> 8) ^ 8'h3c);
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < 8; i++)
      run_access(32'h40 + 4 * i, WORD, 1'b1, 32'h0102_0408 * (i + 3), PRV_M);
    for (int i = 0; i < 8; i++)
      run_access(32'h40 + 4 * i, WORD, 1'b0, '0, PRV_M);
    finish_test("word write and read to RAM");

    // Upper bits of store data must not leak into the lanes
    run_access(32'h100, WORD, 1'b1, 32'ha1b2_c3d4, PRV_M);
    for (int i = 0; i < 4; i++)
      run_access(32'h100 + i, BYTE, 1'b1, 32'hdead_be00 + 32'h11 * (i + 1), PRV_M);
    run_access(32'h100, WORD, 1'b0, '0, PRV_M);
    for (int i = 0; i < 4; i++)
      run_access(32'h100 + i, BYTE, 1'b0, '0, PRV_M);
    for (int i = 0; i < 2; i++)
      run_access(32'h100 + 2 * i, HWORD, 1'b1, 32'hcafe_0000 + 32'h1357 * (i + 1), PRV_M);
    run_access(32'h100, WORD, 1'b0, '0, PRV_M);
    for (int i = 0; i < 2; i++)
      run_access(32'h100 + 2 * i, HWORD, 1'b0, '0, PRV_M);
    finish_test("byte and halfword lanes");

    run_access(32'h201, HWORD, 1'b0, '0, PRV_M);
    run_access(32'h203, HWORD, 1'b1, 32'h0000_beef, PRV_M);
    run_access(32'h202, WORD, 1'b0, '0, PRV_M);
    run_access(32'h201, WORD, 1'b1, 32'h1122_3344, PRV_M);
    run_access(32'h2002, WORD, 1'b1, 32'h5566_7788, PRV_M);
    run_access(32'h2001, WORD, 1'b0, '0, PRV_M);
    run_access(32'h2011, HWORD, 1'b1, 32'h0000_9abc, PRV_M);
    run_access(32'h2013, HWORD, 1'b0, '0, PRV_M);
    finish_test("misaligned RAM and I/O");

    run_access(32'h1000, WORD, 1'b1, 32'hffff_0000, PRV_M);
    run_access(32'h1802, HWORD, 1'b1, 32'h0000_1234, PRV_M);
    run_access(32'h1004, WORD, 1'b0, '0, PRV_M);
    run_access(32'h3000, WORD, 1'b0, '0, PRV_M);
    run_access(32'h2100, WORD, 1'b1, 32'h0bad_0bad, PRV_M);
    finish_test("ROM write and unmapped access");

    run_access(32'h0f00, WORD, 1'b1, 32'h7777_7777, PRV_M);
    run_access(32'h0f00, WORD, 1'b0, '0, PRV_M);
    run_access(32'h0fff, BYTE, 1'b1, 32'h0000_0055, PRV_M);
    run_access(32'h0efc, WORD, 1'b0, '0, PRV_M);
    finish_test("bus error window");

    for (int n = 0; n < N_RAND; n++)
    begin
      region = $unsigned($random(seed)) % 3;
      off    = $random(seed);
      case (region)
        0       : adr = {20'h0, off[11:0]};
        1       : adr = 32'h1000 | off[11:0];
        default : adr = 32'h2000 | off[7:0];
      endcase
      run_access(adr, mem_size_t'($unsigned($random(seed)) % 3), 1'($random(seed)),
                 $random(seed), prv_t'($random(seed)));
    end
    finish_test("random traffic");

    $display("%0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/dmem_bus_model.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_bus_model
  import dmem_pkg::*;
#(
  parameter logic [31:0] SEED = 32'he45b_424b
)
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     stb_i,
  input  word_t    adr_i,
  input  byte_en_t be_i,
  input  logic     we_i,
  input  word_t    d_i,
  output word_t    q_o,
  output logic     ack_o,
  output logic     err_o
);

  // Byte memory covering RAM, ROM and I/O
  logic [7:0] mem [16384];
  integer     seed;
  int         stall;
  logic       busy;

  initial
  begin
    seed  = SEED;
    busy  = 1'b0;
    stall = 0;
    ack_o = 1'b0;
    err_o = 1'b0;
    q_o   = '0;
    // Every address bit feeds the fill byte
    for (int a = 0; a < 16384; a++)
      mem[a] = 8'(a ^ (a >> 8) ^ 8'h3c);
  end

  always @(posedge clk_i)
  begin
    ack_o <= 1'b0;
    err_o <= 1'b0;
    if (rst_i)
      busy = 1'b0;
    else if (stb_i && !ack_o && !err_o)
    begin
      // New transfer, draw 0 to 3 stall cycles
      if (!busy)
      begin
        stall = $unsigned($random(seed)) % 4;
        busy  = 1'b1;
      end
      if (stall > 0)
        stall = stall - 1;
      else
      begin
        busy = 1'b0;
        // Error window, memory left alone
        if (adr_i >= 32'h0f00 && adr_i <= 32'h0fff)
          err_o <= 1'b1;
        else
        begin
          ack_o <= 1'b1;
          for (int i = 0; i < 4; i++)
          begin
            if (we_i && be_i[i])
              mem[adr_i[13:0] + i] <= d_i[8*i +: 8];
            q_o[8*i +: 8] <= mem[adr_i[13:0] + i];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/dmem_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_ctrl
  import dmem_pkg::*;
#(
  parameter int PMA_CNT = 3
)
(
  input  logic      clk_i,
  input  logic      rst_i,

  // Configuration
  input  prv_t      st_prv_i,
  input  pmacfg_t   pma_cfg_i  [PMA_CNT],
  input  word_t     pma_base_i [PMA_CNT],
  input  word_t     pma_top_i  [PMA_CNT],

  // CPU side
  input  logic      mem_req_i,
  input  word_t     mem_adr_i,
  input  mem_size_t mem_size_i,
  input  logic      mem_we_i,
  input  word_t     mem_d_i,
  output word_t     mem_q_o,
  output logic      mem_ack_o,
  output logic      mem_err_o,
  output logic      mem_misaligned_o,

  // BIU side
  output logic      biu_stb_o,
  output word_t     biu_adr_o,
  output byte_en_t  biu_be_o,
  output logic      biu_we_o,
  output prot_t     biu_prot_o,
  output word_t     biu_d_o,
  input  word_t     biu_q_i,
  input  logic      biu_ack_i,
  input  logic      biu_err_i
);

  // Bus completion into the response stage
  logic bus_done;
  logic bus_err;

  dmem_req_if req_if ();

  ////////////////////
  // Check stage
  ////////////////////

  dmem_access_chk #(
    .PMA_CNT    ( PMA_CNT    )
  )
  chk_inst (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .mem_req_i  ( mem_req_i  ),
    .mem_adr_i  ( mem_adr_i  ),
    .mem_size_i ( mem_size_i ),
    .mem_we_i   ( mem_we_i   ),
    .mem_d_i    ( mem_d_i    ),
    .st_prv_i   ( st_prv_i   ),
    .pma_cfg_i  ( pma_cfg_i  ),
    .pma_base_i ( pma_base_i ),
    .pma_top_i  ( pma_top_i  ),
    .req        ( req_if.chk )
  );

  // Bus transfer
  dmem_biu_ctrl ctrl_inst (
    .clk_i      ( clk_i       ),
    .rst_i      ( rst_i       ),
    .req        ( req_if.ctrl ),
    .biu_stb_o  ( biu_stb_o   ),
    .biu_adr_o  ( biu_adr_o   ),
    .biu_be_o   ( biu_be_o    ),
    .biu_we_o   ( biu_we_o    ),
    .biu_prot_o ( biu_prot_o  ),
    .biu_d_o    ( biu_d_o     ),
    .biu_ack_i  ( biu_ack_i   ),
    .biu_err_i  ( biu_err_i   ),
    .bus_done_o ( bus_done    ),
    .bus_err_o  ( bus_err     )
  );

  // Response to the load/store unit
  dmem_resp resp_inst (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .req              ( req_if.resp      ),
    .bus_done_i       ( bus_done         ),
    .bus_err_i        ( bus_err          ),
    .bus_q_i          ( biu_q_i          ),
    .mem_q_o          ( mem_q_o          ),
    .mem_ack_o        ( mem_ack_o        ),
    .mem_err_o        ( mem_err_o        ),
    .mem_misaligned_o ( mem_misaligned_o )
  );

endmodule

`default_nettype wire

/* design/dmem_resp.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_resp
  import dmem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,

  // Lane and cause of the retiring request
  dmem_req_if.resp req,

  // Completion from bus control
  input  logic     bus_done_i,
  input  logic     bus_err_i,
  input  word_t    bus_q_i,

  // CPU response
  output word_t    mem_q_o,
  output logic     mem_ack_o,
  output logic     mem_err_o,
  output logic     mem_misaligned_o
);

  logic       chk_fail;
  logic [4:0] lane_sh;
  word_t      lane;
  word_t      load_q;

  assign chk_fail = req.fault | req.misaligned;

  ////////////////////
  // Load extraction
  ////////////////////

  // Bit offset of the addressed lane
  always_comb
  begin
    case (req.size)
      BYTE    : lane_sh = {req.adr[1:0], 3'b000};
      HWORD   : lane_sh = {req.adr[1], 4'b0000};
      default : lane_sh = '0;
    endcase
  end

  assign lane = bus_q_i >> lane_sh;

  // Zero extend, sign handled in writeback
  always_comb
  begin
    case (req.size)
      BYTE    : load_q = {{(XLEN-8){1'b0}}, lane[7:0]};
      HWORD   : load_q = {{(XLEN-16){1'b0}}, lane[15:0]};
      default : load_q = lane;
    endcase
  end

  ////////////////////
  // Response pulses
  ////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      mem_ack_o        <= 1'b0;
      mem_err_o        <= 1'b0;
      mem_misaligned_o <= 1'b0;
    end
    else
    begin
      mem_ack_o        <= bus_done_i & ~chk_fail & ~bus_err_i;
      mem_err_o        <= bus_done_i & (chk_fail | bus_err_i);
      mem_misaligned_o <= bus_done_i & req.misaligned;
    end
  end

  // Read data only on a clean bus completion
  always_ff @(posedge clk_i)
  begin
    if (bus_done_i && !chk_fail && !bus_err_i)
      mem_q_o <= load_q;
  end

endmodule

`default_nettype wire

/* design/dmem_biu_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_biu_ctrl
  import dmem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,

  // Checked request
  dmem_req_if.ctrl req,

  // BIU
  output logic     biu_stb_o,
  output word_t    biu_adr_o,
  output byte_en_t biu_be_o,
  output logic     biu_we_o,
  output prot_t    biu_prot_o,
  output word_t    biu_d_o,
  input  logic     biu_ack_i,
  input  logic     biu_err_i,

  // Completion towards the response stage
  output logic     bus_done_o,
  output logic     bus_err_o
);

  biu_state_t state;
  biu_state_t state_nxt;
  logic       chk_fail;
  logic       answered;

  assign chk_fail = req.fault | req.misaligned;
  assign answered = biu_ack_i | biu_err_i;

  ////////////////////
  // FSM
  ////////////////////

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE :
        // Failed checks never reach the bus
        if (req.valid && !chk_fail)
          state_nxt = STROBE;
      STROBE :
        // Slave stalls simply keep us here
        if (answered)
          state_nxt = RESP;
      RESP :
        // Response pulse goes out in this cycle
        state_nxt = IDLE;
      default :
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  // Retire a failed request at once, a legal one on the slave answer
  assign req.done   = (state == IDLE   & req.valid & chk_fail)
                    | (state == STROBE & answered);

  assign bus_done_o = req.done;
  assign bus_err_o  = (state == STROBE) & biu_err_i;

  ////////////////////
  // Bus signals
  ////////////////////

  assign biu_stb_o  = (state == STROBE);

  // Word aligned, lanes select the bytes
  assign biu_adr_o  = {req.adr[XLEN-1:2], 2'b00};
  assign biu_we_o   = req.we;
  assign biu_prot_o = req.prot;

  // Lane enables from size and low address bits
  always_comb
  begin
    case (req.size)
      BYTE    : biu_be_o = byte_en_t'(4'b0001) << req.adr[1:0];
      // Odd halfword in an MA region stays in its halfword lane
      HWORD   : biu_be_o = byte_en_t'(4'b0011) << {req.adr[1], 1'b0};
      default : biu_be_o = '1;
    endcase
  end

  // Replicate store data over every lane
  always_comb
  begin
    case (req.size)
      BYTE    : biu_d_o = {4{req.d[7:0]}};
      HWORD   : biu_d_o = {2{req.d[15:0]}};
      default : biu_d_o = req.d;
    endcase
  end

endmodule

`default_nettype wire

/* design/dmem_access_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_access_chk
  import dmem_pkg::*;
#(
  parameter int PMA_CNT = 1
)
(
  input  logic      clk_i,
  input  logic      rst_i,

  // CPU request
  input  logic      mem_req_i,
  input  word_t     mem_adr_i,
  input  mem_size_t mem_size_i,
  input  logic      mem_we_i,
  input  word_t     mem_d_i,

  // Configuration
  input  prv_t      st_prv_i,
  input  pmacfg_t   pma_cfg_i  [PMA_CNT],
  input  word_t     pma_base_i [PMA_CNT],
  input  word_t     pma_top_i  [PMA_CNT],

  // Checked request out
  dmem_req_if.chk   req
);

  logic    capture;
  logic    blank;
  logic    mis_raw;
  logic    mis_chk;
  logic    fault_chk;
  logic    pma_hit;
  pmacfg_t pma_sel;
  prot_t   prot_nxt;

  ////////////////////
  // Alignment
  ////////////////////

  always_comb
  begin
    case (mem_size_i)
      HWORD   : mis_raw = mem_adr_i[0];
      WORD    : mis_raw = |mem_adr_i[1:0];
      default : mis_raw = 1'b0;
    endcase
  end

  ////////////////////
  // PMA lookup
  ////////////////////

  // Walk downwards so the lowest matching region wins
  always_comb
  begin
    pma_hit = 1'b0;
    pma_sel = '0;
    for (int i = PMA_CNT - 1; i >= 0; i--)
    begin
      if (mem_adr_i >= pma_base_i[i] && mem_adr_i <= pma_top_i[i])
      begin
        pma_hit = 1'b1;
        pma_sel = pma_cfg_i[i];
      end
    end
  end

  // Region may tolerate misaligned accesses
  assign mis_chk   = mis_raw & ~(pma_hit & pma_sel[PMA_MA]);

  // No region, or access type not permitted
  assign fault_chk = ~pma_hit
                   | ( mem_we_i & ~pma_sel[PMA_W])
                   | (~mem_we_i & ~pma_sel[PMA_R]);

  // Data access, privileged unless user mode
  always_comb
  begin
    prot_nxt            = '0;
    prot_nxt[PROT_DATA] = 1'b1;
    prot_nxt[PROT_PRIV] = (st_prv_i != PRV_U);
  end

  ////////////////////
  // Request register
  ////////////////////

  // Skip the response cycle, CPU still holds the old request there
  assign capture = mem_req_i & ~req.valid & ~blank;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      req.valid      <= 1'b0;
      req.misaligned <= 1'b0;
      req.fault      <= 1'b0;
      blank          <= 1'b0;
    end
    else
    begin
      blank <= req.done;
      if (capture)
      begin
        req.valid      <= 1'b1;
        req.misaligned <= mis_chk;
        req.fault      <= fault_chk;
      end
      else if (req.done)
        req.valid <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk_i)
  begin
    if (capture)
    begin
      req.adr  <= mem_adr_i;
      req.size <= mem_size_i;
      req.we   <= mem_we_i;
      req.d    <= mem_d_i;
      req.prot <= prot_nxt;
    end
  end

endmodule

`default_nettype wire

/* design/dmem_req_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface dmem_req_if
  import dmem_pkg::*;
();

  // Checked request, held until done
  logic      valid;
  word_t     adr;
  mem_size_t size;
  logic      we;
  word_t     d;
  prot_t     prot;

  // Check results for the held request
  logic      misaligned;
  logic      fault;

  // Request retired, one cycle
  logic      done;

  // Check stage owns the request
  modport chk  (output valid, adr, size, we, d, prot, misaligned, fault,
                input  done);

  // Bus control consumes it and retires it
  modport ctrl (input  valid, adr, size, we, d, prot, misaligned, fault,
                output done);

  // Response needs the lane and the cause
  modport resp (input  adr, size, misaligned, fault);

endinterface

`default_nettype wire

/* design/dmem_pkg.sv */
`default_nettype none

package dmem_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // RV32 only
  localparam int XLEN = 32;

  // Address or data word
  typedef logic [XLEN-1:0] word_t;

  // One enable per byte lane
  typedef logic [XLEN/8-1:0] byte_en_t;

  // Transfer size as issued by the load/store unit
  typedef enum logic [1:0]
  {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10
  } mem_size_t;

  ////////////////////
  // Privilege
  ////////////////////

  typedef logic [1:0] prv_t;

  localparam prv_t PRV_U = 2'b00;
  localparam prv_t PRV_M = 2'b11;

  ////////////////////
  // Bus protection
  ////////////////////

  typedef logic [2:0] prot_t;

  // Bit positions in prot_t
  localparam int PROT_DATA  = 0;
  localparam int PROT_PRIV  = 1;
  localparam int PROT_INSTR = 2;

  // PMA region attributes, bit positions in pmacfg_t
  typedef logic [2:0] pmacfg_t;

  localparam int PMA_R  = 0;
  localparam int PMA_W  = 1;
  localparam int PMA_MA = 2;

  // BIU transfer sequencing
  typedef enum logic [1:0]
  {
    IDLE,
    STROBE,
    RESP
  } biu_state_t;

endpackage

`default_nettype wire
